//--- hdl/bus_pkg.sv
// Bus-side types and sizes shared by the controller, the RAM devices and the read merge
package bus_pkg;

    // --------------------------------------------------
    // Data unit on the bus
    // --------------------------------------------------
    localparam int NIBBLE_BITS = 4;                     // Width of one bus transfer

    typedef logic [NIBBLE_BITS-1:0] nibble_t;

    localparam nibble_t IDLE_NIBBLE = '1;               // Undriven bus reads as all ones

    // --------------------------------------------------
    // Bus cycle timing
    // --------------------------------------------------
    localparam int NUM_PHASES   = 4;                    // Clocks per bus cycle
    localparam int STROBE_PHASE = 2;                    // Devices latch here
    localparam int SAMPLE_PHASE = NUM_PHASES - 1;       // Controller samples read data here

    // What the current bus cycle carries
    typedef enum logic [1:0] {
        KIND_IDLE = 2'd0,                               // No transaction running
        KIND_CMD  = 2'd1,                               // Command code
        KIND_ADDR = 2'd2,                               // One address nibble
        KIND_DATA = 2'd3                                // Write data or read reply
    } cycle_kind_t;

    // Controller drive, fanned out to every device
    typedef struct packed {
        nibble_t     nibble;                            // Payload of this cycle
        cycle_kind_t kind;                              // Meaning of payload
        logic        strobe;                            // One clock, in strobe phase
    } bus_drive_t;

    // --------------------------------------------------
    // Device population
    // --------------------------------------------------
    localparam int NUM_DEVICES = 4;                     // RAM devices on the chain
    localparam int WINDOW_BITS = 8;                     // Offset bits inside one window

endpackage

//--- hdl/host_pkg.sv
// Host-side request and response formats, plus the transaction layout the controller follows
package host_pkg;

    // --------------------------------------------------
    // Address layout
    // --------------------------------------------------
    localparam int ADDR_NIBBLES = 3;                    // Address nibbles per transaction
    localparam int ADDR_BITS    = ADDR_NIBBLES * bus_pkg::NIBBLE_BITS;

    // Bus cycles per transaction is CMD, then address nibbles, then DATA
    localparam int XFER_CYCLES = ADDR_NIBBLES + 2;
    localparam int CYCLE_BITS  = $clog2(XFER_CYCLES);

    localparam logic [CYCLE_BITS-1:0] CMD_CYCLE  = '0;
    localparam logic [CYCLE_BITS-1:0] DATA_CYCLE = CYCLE_BITS'(XFER_CYCLES - 1);

    // Command codes, sent as is in the CMD cycle
    typedef enum logic [1:0] {
        CMD_READ         = 2'd0,
        CMD_WRITE        = 2'd1,
        CMD_CONFIG       = 2'd2,                        // Map next free device
        CMD_UNCONFIG_ALL = 2'd3                         // Unmap every device
    } host_cmd_t;

    typedef struct packed {
        host_cmd_t                cmd;
        logic [ADDR_BITS-1:0]     addr;                 // Top nibble selects window
        bus_pkg::nibble_t         wdata;                // Only used by WRITE
    } host_req_t;

    typedef struct packed {
        bus_pkg::nibble_t rdata;                        // Merged read nibble
        logic             hit;                          // Some device answered
    } host_rsp_t;

endpackage

//--- hdl/nibble_bus_controller.sv
// Bus controller: phase ring, host req/ack handshake and the five-cycle transaction sequencer
`timescale 1ns/1ps

module nibble_bus_controller (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_req,
    input  host_pkg::host_req_t i_req_data,
    output logic                o_ack,
    output host_pkg::host_rsp_t o_rsp,
    output bus_pkg::bus_drive_t o_drive,
    input  bus_pkg::nibble_t    i_merge_nibble,
    input  logic                i_merge_hit
);

    typedef enum logic [1:0] {
        ST_IDLE,                                        // Waiting for a request
        ST_RUN,                                         // Bus cycles in flight
        ST_ACK_HIGH,                                    // Reply held for host
        ST_ACK_DROP                                     // Ack just fell
    } state_t;

    state_t                             state;
    logic [bus_pkg::NUM_PHASES-1:0]     phases;         // One-hot phase ring
    logic                               started;        // First phase 0 reached
    logic [host_pkg::CYCLE_BITS-1:0]    cycle_idx;      // Bus cycle within transaction
    logic                               ack_q;
    host_pkg::host_req_t                req_q;          // Latched request
    host_pkg::host_rsp_t                rsp_q;          // Captured reply
    logic                               accept;
    logic                               in_cycle;
    logic                               end_of_cycle;
    logic                               last_cycle;

    // --------------------------------------------------
    // Phase ring
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phases <= {{(bus_pkg::NUM_PHASES-1){1'b0}}, 1'b1};  // Phase 0 after reset
        end else begin
            phases <= {phases[bus_pkg::NUM_PHASES-2:0], phases[bus_pkg::NUM_PHASES-1]};
        end
    end

    assign accept       = (state == ST_IDLE) && i_req && !ack_q;
    assign in_cycle     = (state == ST_RUN) && started;
    assign end_of_cycle = phases[bus_pkg::SAMPLE_PHASE];    // Next clock is phase 0
    assign last_cycle   = (cycle_idx == host_pkg::DATA_CYCLE);

    // --------------------------------------------------
    // Handshake FSM and cycle counter
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= ST_IDLE;
            started   <= 1'b0;
            cycle_idx <= host_pkg::CMD_CYCLE;
            ack_q     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state     <= ST_RUN;
                        started   <= end_of_cycle;  // Phase 0 may be the very next clock
                        cycle_idx <= host_pkg::CMD_CYCLE;
                    end
                end
                ST_RUN: begin
                    if (!started) begin
                        started <= end_of_cycle;    // Align to cycle boundary
                    end else if (end_of_cycle) begin
                        if (last_cycle) begin
                            state   <= ST_ACK_HIGH;
                            ack_q   <= 1'b1;        // Reply already captured
                            started <= 1'b0;
                        end else begin
                            cycle_idx <= cycle_idx + 1'b1;
                        end
                    end
                end
                ST_ACK_HIGH: begin
                    if (!i_req) begin               // Host took the reply
                        state <= ST_ACK_DROP;
                        ack_q <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;               // One guard clock with ack low
                end
            endcase
        end
    end

    // Request and reply payload
    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_q <= i_req_data;
        end
        if (in_cycle && last_cycle && end_of_cycle) begin
            rsp_q.rdata <= i_merge_nibble;          // Phase 3 of DATA cycle
            rsp_q.hit   <= i_merge_hit;
        end
    end

    // --------------------------------------------------
    // Bus drive
    // --------------------------------------------------
    always_comb begin
        o_drive.kind   = bus_pkg::KIND_IDLE;
        o_drive.nibble = bus_pkg::IDLE_NIBBLE;
        o_drive.strobe = in_cycle && phases[bus_pkg::STROBE_PHASE];
        if (in_cycle) begin
            if (cycle_idx == host_pkg::CMD_CYCLE) begin
                o_drive.kind   = bus_pkg::KIND_CMD;
                o_drive.nibble = bus_pkg::nibble_t'(req_q.cmd); // Zero extended code
            end else if (last_cycle) begin
                o_drive.kind   = bus_pkg::KIND_DATA;
                o_drive.nibble = req_q.wdata;
            end else begin
                o_drive.kind = bus_pkg::KIND_ADDR;
                // Most significant nibble goes out first
                for (int i = 1; i <= host_pkg::ADDR_NIBBLES; i++) begin
                    if (cycle_idx == host_pkg::CYCLE_BITS'(i)) begin
                        o_drive.nibble = req_q.addr[(host_pkg::ADDR_NIBBLES - i)
                                                    * bus_pkg::NIBBLE_BITS
                                                    +: bus_pkg::NIBBLE_BITS];
                    end
                end
            end
        end
    end

    assign o_ack = ack_q;
    assign o_rsp = rsp_q;

endmodule

//--- hdl/nibble_ram_device.sv
// One daisy-chained RAM device of 256 nibbles, mapped by CONFIG to the window given by its base
`timescale 1ns/1ps

module nibble_ram_device (
    input  logic                i_clk,
    input  logic                i_reset,
    input  bus_pkg::bus_drive_t i_drive,
    input  logic                i_daisy,
    output logic                o_daisy,
    output bus_pkg::nibble_t    o_nibble,
    output logic                o_active
);

    host_pkg::host_cmd_t                cmd_q;          // Command of current transaction
    logic [host_pkg::ADDR_BITS-1:0]     addr_q;         // Address shift register
    logic                               mapped_q;
    bus_pkg::nibble_t                   base_q;         // Window base, top address nibble
    bus_pkg::nibble_t                   mem [2**bus_pkg::WINDOW_BITS];
    logic [bus_pkg::WINDOW_BITS-1:0]    offset;
    bus_pkg::nibble_t                   addr_top;
    logic                               window_hit;
    logic                               cmd_strobe;
    logic                               addr_strobe;
    logic                               data_strobe;

    // --------------------------------------------------
    // Strobe decode
    // --------------------------------------------------
    assign cmd_strobe  = i_drive.strobe && (i_drive.kind == bus_pkg::KIND_CMD);
    assign addr_strobe = i_drive.strobe && (i_drive.kind == bus_pkg::KIND_ADDR);
    assign data_strobe = i_drive.strobe && (i_drive.kind == bus_pkg::KIND_DATA);

    assign offset     = addr_q[bus_pkg::WINDOW_BITS-1:0];
    assign addr_top   = addr_q[host_pkg::ADDR_BITS-1 -: bus_pkg::NIBBLE_BITS];
    assign window_hit = mapped_q && (base_q == addr_top);

    // Command and mapping state
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cmd_q    <= host_pkg::CMD_READ;
            mapped_q <= 1'b0;                       // Nothing mapped at reset
        end else begin
            if (cmd_strobe) begin
                cmd_q <= host_pkg::host_cmd_t'(i_drive.nibble[$bits(host_pkg::host_cmd_t)-1:0]);
            end
            if (data_strobe) begin
                case (cmd_q)
                    host_pkg::CMD_CONFIG: begin
                        if (!mapped_q && i_daisy) begin
                            mapped_q <= 1'b1;       // First free device in chain
                        end
                    end
                    host_pkg::CMD_UNCONFIG_ALL: begin
                        mapped_q <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Address nibbles arrive most significant first
    always_ff @(posedge i_clk) begin
        if (addr_strobe) begin
            addr_q <= {addr_q[host_pkg::ADDR_BITS-bus_pkg::NIBBLE_BITS-1:0], i_drive.nibble};
        end
        if (data_strobe && (cmd_q == host_pkg::CMD_CONFIG) && !mapped_q && i_daisy) begin
            base_q <= addr_top;                     // Base only counts once mapped
        end
    end

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (data_strobe && (cmd_q == host_pkg::CMD_WRITE) && window_hit) begin
            mem[offset] <= i_drive.nibble;
        end
    end

    assign o_nibble = mem[offset];                  // Async read, merge picks it up
    assign o_active = window_hit && (cmd_q == host_pkg::CMD_READ)
                      && (i_drive.kind == bus_pkg::KIND_DATA);
    assign o_daisy  = i_daisy && mapped_q;          // Pass chain on once taken

endmodule

//--- hdl/nibble_read_merge.sv
// Read merge: picks the reply of the highest-index active device, idle bus reads as all ones
`timescale 1ns/1ps

module nibble_read_merge (
    input  bus_pkg::nibble_t [bus_pkg::NUM_DEVICES-1:0] i_nibbles,
    input  logic [bus_pkg::NUM_DEVICES-1:0]             i_active,
    output bus_pkg::nibble_t                            o_nibble,
    output logic                                        o_hit
);

    // --------------------------------------------------
    // Priority select
    // --------------------------------------------------
    // Later devices override earlier ones so the last active one wins
    always_comb begin
        o_nibble = bus_pkg::IDLE_NIBBLE;            // Pulled high when nobody drives
        for (int i = 0; i < bus_pkg::NUM_DEVICES; i++) begin
            if (i_active[i]) begin
                o_nibble = i_nibbles[i];
            end
        end
    end

    assign o_hit = |i_active;                       // Any device answered

endmodule

//--- hdl/nibble_bus_top.sv
// Top level of the nibble bus: controller, chain of RAM devices and the read merge
`timescale 1ns/1ps

module nibble_bus_top (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_req,
    input  host_pkg::host_req_t i_req_data,
    output logic                o_ack,
    output host_pkg::host_rsp_t o_rsp
);

    bus_pkg::bus_drive_t                            drive;          // Shared by all devices
    bus_pkg::nibble_t [bus_pkg::NUM_DEVICES-1:0]    dev_nibbles;
    logic [bus_pkg::NUM_DEVICES-1:0]                dev_active;
    logic [bus_pkg::NUM_DEVICES:0]                  daisy;          // Top bit is open chain end
    bus_pkg::nibble_t                               merge_nibble;
    logic                                           merge_hit;

    // --------------------------------------------------
    // Bus controller
    // --------------------------------------------------
    nibble_bus_controller u_controller (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_req          (i_req),
        .i_req_data     (i_req_data),
        .o_ack          (o_ack),
        .o_rsp          (o_rsp),
        .o_drive        (drive),
        .i_merge_nibble (merge_nibble),
        .i_merge_hit    (merge_hit)
    );

    // --------------------------------------------------
    // Device chain
    // --------------------------------------------------
    assign daisy[0] = 1'b1;                         // Head of chain always enabled

    for (genvar g = 0; g < bus_pkg::NUM_DEVICES; g++) begin : g_dev
        nibble_ram_device u_dev (
            .i_clk    (i_clk),
            .i_reset  (i_reset),
            .i_drive  (drive),
            .i_daisy  (daisy[g]),
            .o_daisy  (daisy[g+1]),                 // Feeds next device
            .o_nibble (dev_nibbles[g]),
            .o_active (dev_active[g])
        );
    end

    // --------------------------------------------------
    // Read merge
    // --------------------------------------------------
    nibble_read_merge u_merge (
        .i_nibbles (dev_nibbles),
        .i_active  (dev_active),
        .o_nibble  (merge_nibble),
        .o_hit     (merge_hit)
    );

endmodule

//--- bench/tb_nibble_bus.sv
// Random self-checking testbench that drives the nibble bus top level and checks it against a device model
`timescale 1ns/1ps

module tb_nibble_bus;

    localparam int ACK_TIMEOUT  = 64;                   // Clocks allowed per ack edge
    localparam int OFFSET_RANGE = 24;                   // Small offsets so cells repeat

    logic                   i_clk = 1'b0;
    logic                   i_reset;
    logic                   i_req;
    host_pkg::host_req_t    i_req_data;
    logic                   o_ack;
    host_pkg::host_rsp_t    o_rsp;

    int unsigned            rng_state = 38745;          // LCG state

    // Device model
    bit                     model_mapped [bus_pkg::NUM_DEVICES];
    bus_pkg::nibble_t       model_base [bus_pkg::NUM_DEVICES];
    bus_pkg::nibble_t       model_mem [bus_pkg::NUM_DEVICES][2**bus_pkg::WINDOW_BITS];
    bit                     model_written [bus_pkg::NUM_DEVICES][2**bus_pkg::WINDOW_BITS];
    bus_pkg::nibble_t       bases [5];                  // Last one is never mapped

    nibble_bus_top i_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_req      (i_req),
        .i_req_data (i_req_data),
        .o_ack      (o_ack),
        .o_rsp      (o_rsp)
    );

    always #4 i_clk = ~i_clk;                           // 8 ns period

    // --------------------------------------------------
    // Random numbers and failure handling
    // --------------------------------------------------
    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return (rng_state >> 12) % n;                   // Drop weak low bits
    endfunction

    function automatic logic [host_pkg::ADDR_BITS-1:0] random_addr(input bus_pkg::nibble_t base);
        return {base, 8'(rand_below(OFFSET_RANGE))};
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL time=%0t o_ack got=%b expected=%b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rsp(input host_pkg::host_rsp_t got, input host_pkg::host_rsp_t exp,
                             input bit data_known);
        if (got.hit !== exp.hit) begin
            $display("FAIL time=%0t o_rsp.hit got=%b expected=%b", $time, got.hit, exp.hit);
            abort_run();
        end else if (data_known && (got.rdata !== exp.rdata)) begin
            $display("FAIL time=%0t o_rsp.rdata got=%h expected=%h",
                     $time, got.rdata, exp.rdata);
            abort_run();
        end
    endtask

    // --------------------------------------------------
    // Reference model of the device chain
    // --------------------------------------------------
    // Expected reply where the last matching device wins
    task automatic model_expect(input host_pkg::host_req_t req,
                                output host_pkg::host_rsp_t exp, output bit data_known);
        exp.rdata  = 4'hF;                              // Idle bus reads all ones
        exp.hit    = 1'b0;
        data_known = 1'b1;
        if (req.cmd == host_pkg::CMD_READ) begin
            for (int d = 0; d < bus_pkg::NUM_DEVICES; d++) begin
                if (model_mapped[d] && (model_base[d] == req.addr[11:8])) begin
                    exp.rdata  = model_mem[d][req.addr[7:0]];
                    exp.hit    = 1'b1;
                    data_known = model_written[d][req.addr[7:0]];   // Unwritten reads X
                end
            end
        end
    endtask

    task automatic model_apply(input host_pkg::host_req_t req);
        bit taken;
        taken = 1'b0;
        for (int d = 0; d < bus_pkg::NUM_DEVICES; d++) begin
            case (req.cmd)
                host_pkg::CMD_WRITE: begin
                    if (model_mapped[d] && (model_base[d] == req.addr[11:8])) begin
                        model_mem[d][req.addr[7:0]]     = req.wdata;    // Every match stores
                        model_written[d][req.addr[7:0]] = 1'b1;
                    end
                end
                host_pkg::CMD_CONFIG: begin
                    if (!taken && !model_mapped[d]) begin   // Lowest free device
                        model_mapped[d] = 1'b1;
                        model_base[d]   = req.addr[11:8];
                        taken           = 1'b1;
                    end
                end
                host_pkg::CMD_UNCONFIG_ALL: model_mapped[d] = 1'b0;
                default: begin
                end
            endcase
        end
    endtask

    // --------------------------------------------------
    // Four-phase handshake
    // --------------------------------------------------
    // Called and left at 1 ns after a rising edge
    task automatic run_transaction(input host_pkg::host_cmd_t cmd,
                                   input logic [host_pkg::ADDR_BITS-1:0] addr,
                                   input bus_pkg::nibble_t wdata);
        host_pkg::host_req_t req;
        host_pkg::host_rsp_t exp;
        bit                  data_known;
        int                  wait_cycles;
        int                  hold_cycles;
        int                  gap_cycles;
        req.cmd   = cmd;
        req.addr  = addr;
        req.wdata = wdata;
        model_expect(req, exp, data_known);
        model_apply(req);
        i_req_data = req;
        i_req      = 1'b1;
        wait_cycles = 0;
        while (o_ack !== 1'b1) begin
            if (wait_cycles == ACK_TIMEOUT) begin
                $display("Timeout: o_ack did not rise after i_req was raised");
                abort_run();
            end
            @(posedge i_clk);
            #1;
            wait_cycles++;
        end
        check_rsp(o_rsp, exp, data_known);
        hold_cycles = rand_below(5);                    // Host slow to take the reply
        repeat (hold_cycles) begin
            @(posedge i_clk);
            #1;
            check_ack(o_ack, 1'b1);
        end
        i_req      = 1'b0;
        i_req_data = host_pkg::host_req_t'(rand_below(1 << 18));  // Junk once req is low
        wait_cycles = 0;
        while (o_ack !== 1'b0) begin
            if (wait_cycles == ACK_TIMEOUT) begin
                $display("Timeout: o_ack did not fall after i_req was lowered");
                abort_run();
            end
            @(posedge i_clk);
            #1;
            wait_cycles++;
        end
        gap_cycles = rand_below(4);
        repeat (gap_cycles) begin
            @(posedge i_clk);
            #1;
            check_ack(o_ack, 1'b0);                     // No ack without a request
        end
    endtask

    task automatic random_mix(input int count, input int num_bases);
        bus_pkg::nibble_t base;
        for (int n = 0; n < count; n++) begin
            base = bases[rand_below(num_bases)];
            if (rand_below(2) == 0) begin
                run_transaction(host_pkg::CMD_WRITE, random_addr(base),
                                bus_pkg::nibble_t'(rand_below(16)));
            end else begin
                run_transaction(host_pkg::CMD_READ, random_addr(base), '0);
            end
        end
    endtask

    task automatic sweep_reads(input int num_bases);
        for (int b = 0; b < num_bases; b++) begin
            for (int off = 0; off < OFFSET_RANGE; off++) begin
                run_transaction(host_pkg::CMD_READ, {bases[b], 8'(off)}, '0);
            end
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int start;
        i_reset    = 1'b1;
        i_req      = 1'b0;
        i_req_data = '0;
        repeat (3) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check_ack(o_ack, 1'b0);

        // Nothing mapped yet so all reads miss
        repeat (8) run_transaction(host_pkg::CMD_READ, 12'(rand_below(4096)), '0);

        // Five distinct bases since stride 3 is coprime with 16
        start = rand_below(16);
        for (int b = 0; b < 5; b++) begin
            bases[b] = bus_pkg::nibble_t'(start + 3 * b);
        end
        for (int b = 0; b < 5; b++) begin
            run_transaction(host_pkg::CMD_CONFIG, random_addr(bases[b]), '0);  // Fifth is extra
        end
        repeat (4) run_transaction(host_pkg::CMD_READ, random_addr(bases[4]), '0);

        random_mix(120, 5);
        sweep_reads(4);

        // Unmap and remap in the same order
        run_transaction(host_pkg::CMD_UNCONFIG_ALL, '0, '0);
        random_mix(12, 5);                              // Writes land nowhere
        for (int b = 0; b < 4; b++) begin
            run_transaction(host_pkg::CMD_CONFIG, random_addr(bases[b]), '0);
        end
        sweep_reads(4);

        // Devices 1 and 3 share a window
        run_transaction(host_pkg::CMD_UNCONFIG_ALL, '0, '0);
        run_transaction(host_pkg::CMD_CONFIG, random_addr(bases[0]), '0);
        run_transaction(host_pkg::CMD_CONFIG, random_addr(bases[1]), '0);
        run_transaction(host_pkg::CMD_CONFIG, random_addr(bases[2]), '0);
        run_transaction(host_pkg::CMD_CONFIG, random_addr(bases[1]), '0);
        sweep_reads(2);                                 // Device 3 holds older data
        random_mix(60, 2);
        sweep_reads(4);

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- files.f
hdl/bus_pkg.sv
hdl/host_pkg.sv
hdl/nibble_bus_controller.sv
hdl/nibble_ram_device.sv
hdl/nibble_read_merge.sv
hdl/nibble_bus_top.sv
bench/tb_nibble_bus.sv
